/* core_params.svh */
/*
 * Core parameters: data and register file widths, legal major
 * opcodes and the funct fields of the kept RV32I subset
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file geometry
`define CORE_XLEN        32
`define CORE_NUM_REGS    32
`define CORE_REG_AW      5

// Major opcodes, bits [6:0]
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_LUI     7'b0110111

// funct7 for register-register forms
`define CORE_F7_BASE     7'b0000000
`define CORE_F7_SUB      7'b0100000

// funct3 encodings
`define CORE_F3_ADD      3'b000
`define CORE_F3_SLT      3'b010
`define CORE_F3_XOR      3'b100
`define CORE_F3_OR       3'b110
`define CORE_F3_AND      3'b111

`endif

/* core_pkg.sv */
/*
 * Core package: word and register address types, ALU and bypass
 * encodings, and the pipe structs passed between the stages
 */
`include "core_params.svh"

package core_pkg;

  // Basic vector types
  typedef logic [`CORE_XLEN-1:0]   word_t;
  typedef logic [`CORE_REG_AW-1:0] rf_addr_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    // LUI, operand b straight through
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // Operand source in decode
  typedef enum logic [1:0] {
    REGFILE = 2'd0,
    FROM_EX = 2'd1,
    FROM_WB = 2'd2
  } byp_sel_e;

  // Instruction entering execute
  typedef struct packed {
    logic     valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    alu_op_e  alu_op;
    word_t    alu_operand_a;
    word_t    alu_operand_b;
  } id_ex_pipe_t;

  // Result waiting for write-back
  typedef struct packed {
    logic     valid;
    logic     rf_we;
    rf_addr_t rf_waddr;
    word_t    rf_wdata;
  } ex_wb_pipe_t;

  // Bypass selects from the controller
  typedef struct packed {
    byp_sel_e op_a_sel;
    byp_sel_e op_b_sel;
  } ctrl_byp_t;

endpackage

/* register_file.sv */
/*
 * Register file: x1..x31 cleared by reset, x0 hardwired to zero,
 * two asynchronous read ports and one synchronous write port
 */
`include "core_params.svh"

module register_file import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  // No storage behind x0
  word_t mem [1:`CORE_NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old value during a same-cycle write
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem[raddr_b_i];

endmodule

/* id_stage.sv */
/*
 * Decode stage: decodes the instruction, picks operands from the
 * register file or the bypass paths and loads the ID/EX pipe
 */
`include "core_params.svh"

module id_stage import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  word_t       instr_i,
  input  ctrl_byp_t   ctrl_byp_i,
  input  word_t       rf_rdata_a_i,
  input  word_t       rf_rdata_b_i,
  input  word_t       ex_result_i,
  input  word_t       wb_result_i,
  output rf_addr_t    rf_raddr_a_o,
  output rf_addr_t    rf_raddr_b_o,
  output logic        rf_re_a_o,
  output logic        rf_re_b_o,
  output id_ex_pipe_t id_ex_pipe_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rf_addr_t   rd;

  // Decoder outputs
  logic    illegal;
  logic    use_imm;
  logic    re_a;
  logic    re_b;
  alu_op_e alu_op;
  word_t   imm;
  logic    rf_we;
  word_t   operand_a;
  word_t   operand_b;

  // Three-way operand mux, same for both sources
  function automatic word_t sel_operand(byp_sel_e sel, word_t rf_val,
                                        word_t ex_val, word_t wb_val);
    word_t res;
    case (sel)
      FROM_EX: res = ex_val;
      FROM_WB: res = wb_val;
      default: res = rf_val;
    endcase
    return res;
  endfunction

  assign opcode       = instr_i[6:0];
  assign rd           = instr_i[11:7];
  assign funct3       = instr_i[14:12];
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign funct7       = instr_i[31:25];

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal = 1'b0;
    use_imm = 1'b0;
    re_a    = 1'b0;
    re_b    = 1'b0;
    alu_op  = ALU_ADD;
    imm     = '0;
    case (opcode)
      `CORE_OPC_OP: begin
        re_a = 1'b1;
        re_b = 1'b1;
        if (funct7 == `CORE_F7_BASE) begin
          case (funct3)
            `CORE_F3_ADD: alu_op = ALU_ADD;
            `CORE_F3_SLT: alu_op = ALU_SLT;
            `CORE_F3_XOR: alu_op = ALU_XOR;
            `CORE_F3_OR:  alu_op = ALU_OR;
            `CORE_F3_AND: alu_op = ALU_AND;
            default:      illegal = 1'b1;
          endcase
        end else if (funct7 == `CORE_F7_SUB && funct3 == `CORE_F3_ADD) begin
          alu_op = ALU_SUB;
        end else begin
          illegal = 1'b1;
        end
      end
      `CORE_OPC_OP_IMM: begin
        re_a    = 1'b1;
        use_imm = 1'b1;
        // I-type, sign extended
        imm     = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};
        case (funct3)
          `CORE_F3_ADD: alu_op = ALU_ADD;
          `CORE_F3_XOR: alu_op = ALU_XOR;
          `CORE_F3_OR:  alu_op = ALU_OR;
          `CORE_F3_AND: alu_op = ALU_AND;
          // SLTI and shifts not kept
          default:      illegal = 1'b1;
        endcase
      end
      `CORE_OPC_LUI: begin
        use_imm = 1'b1;
        alu_op  = ALU_PASS_B;
        imm     = {instr_i[31:12], 12'b0};
      end
      default: illegal = 1'b1;
    endcase
  end

  // Source reads only for legal, strobed instructions
  assign rf_re_a_o = instr_valid_i & re_a & ~illegal;
  assign rf_re_b_o = instr_valid_i & re_b & ~illegal;

  // Illegal or x0 target becomes a bubble
  assign rf_we = instr_valid_i & ~illegal & (rd != '0);

  // Operand selection
  assign operand_a = sel_operand(ctrl_byp_i.op_a_sel, rf_rdata_a_i, ex_result_i, wb_result_i);
  assign operand_b = use_imm ? imm :
                     sel_operand(ctrl_byp_i.op_b_sel, rf_rdata_b_i, ex_result_i, wb_result_i);

  //////////////////////////////////////////////////////////////////////
  // ID/EX pipe register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // Payload only moves with a new instruction
    if (instr_valid_i) begin
      id_ex_pipe_o.rf_waddr      <= rd;
      id_ex_pipe_o.alu_op        <= alu_op;
      id_ex_pipe_o.alu_operand_a <= operand_a;
      id_ex_pipe_o.alu_operand_b <= operand_b;
    end
    if (rst_i) begin
      id_ex_pipe_o.valid <= 1'b0;
      id_ex_pipe_o.rf_we <= 1'b0;
    end else begin
      id_ex_pipe_o.valid <= instr_valid_i;
      id_ex_pipe_o.rf_we <= rf_we;
    end
  end

endmodule

/* ex_stage.sv */
/*
 * Execute stage: ALU and the EX/WB pipe register
 */
`include "core_params.svh"

module ex_stage import core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output word_t       ex_result_o,
  output ex_wb_pipe_t ex_wb_pipe_o
);

  word_t a;
  word_t b;
  logic  lt;

  assign a  = id_ex_pipe_i.alu_operand_a;
  assign b  = id_ex_pipe_i.alu_operand_b;
  // Signed compare for SLT
  assign lt = $signed(a) < $signed(b);

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_ADD:    ex_result_o = a + b;
      ALU_SUB:    ex_result_o = a - b;
      ALU_AND:    ex_result_o = a & b;
      ALU_OR:     ex_result_o = a | b;
      ALU_XOR:    ex_result_o = a ^ b;
      ALU_SLT:    ex_result_o = {{(`CORE_XLEN-1){1'b0}}, lt};
      ALU_PASS_B: ex_result_o = b;
      default:    ex_result_o = '0;
    endcase
  end

  // EX/WB pipe, payload follows a valid entry
  always_ff @(posedge clk_i) begin
    if (id_ex_pipe_i.valid) begin
      ex_wb_pipe_o.rf_waddr <= id_ex_pipe_i.rf_waddr;
      ex_wb_pipe_o.rf_wdata <= ex_result_o;
    end
    if (rst_i) begin
      ex_wb_pipe_o.valid <= 1'b0;
      ex_wb_pipe_o.rf_we <= 1'b0;
    end else begin
      ex_wb_pipe_o.valid <= id_ex_pipe_i.valid;
      ex_wb_pipe_o.rf_we <= id_ex_pipe_i.rf_we;
    end
  end

endmodule

/* controller.sv */
/*
 * Controller: RAW hazard detection against EX and WB, and the
 * bypass selects for both decode operands
 */
module controller import core_pkg::*; (
  input  rf_addr_t    rf_raddr_a_i,
  input  rf_addr_t    rf_raddr_b_i,
  input  logic        rf_re_a_i,
  input  logic        rf_re_b_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  output ctrl_byp_t   ctrl_byp_o
);

  // Pending writes in EX and WB
  logic ex_wr;
  logic wb_wr;

  assign ex_wr = id_ex_pipe_i.valid & id_ex_pipe_i.rf_we;
  assign wb_wr = ex_wb_pipe_i.valid & ex_wb_pipe_i.rf_we;

  // Forwarding rule for one source, EX wins over WB
  function automatic byp_sel_e fwd_sel(rf_addr_t raddr, logic re);
    byp_sel_e sel;
    if (!re || raddr == '0) begin
      sel = REGFILE;
    end else if (ex_wr && id_ex_pipe_i.rf_waddr == raddr) begin
      sel = FROM_EX;
    end else if (wb_wr && ex_wb_pipe_i.rf_waddr == raddr) begin
      sel = FROM_WB;
    end else begin
      // Older writes already in the register file
      sel = REGFILE;
    end
    return sel;
  endfunction

  assign ctrl_byp_o.op_a_sel = fwd_sel(rf_raddr_a_i, rf_re_a_i);
  assign ctrl_byp_o.op_b_sel = fwd_sel(rf_raddr_b_i, rf_re_b_i);

endmodule

/* core.sv */
/*
 * Core top level: three-stage integer pipeline with full
 * forwarding and a register-write report port
 */
module core import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     instr_valid_i,
  input  word_t    instr_i,
  output logic     wb_valid_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_wdata_o
);

  // Pipes between stages
  id_ex_pipe_t id_ex_pipe;
  ex_wb_pipe_t ex_wb_pipe;
  ctrl_byp_t   ctrl_byp;

  // Decode source reads
  rf_addr_t rf_raddr_a;
  rf_addr_t rf_raddr_b;
  logic     rf_re_a;
  logic     rf_re_b;
  word_t    rf_rdata_a;
  word_t    rf_rdata_b;

  // Unregistered ALU result for EX forwarding
  word_t ex_result;

  // Write-back port
  logic rf_we_wb;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  id_stage id_stage_inst (
    .clk_i         ( clk_i               ),
    .rst_i         ( rst_i               ),
    .instr_valid_i ( instr_valid_i       ),
    .instr_i       ( instr_i             ),
    .ctrl_byp_i    ( ctrl_byp            ),
    .rf_rdata_a_i  ( rf_rdata_a          ),
    .rf_rdata_b_i  ( rf_rdata_b          ),
    .ex_result_i   ( ex_result           ),
    .wb_result_i   ( ex_wb_pipe.rf_wdata ),
    .rf_raddr_a_o  ( rf_raddr_a          ),
    .rf_raddr_b_o  ( rf_raddr_b          ),
    .rf_re_a_o     ( rf_re_a             ),
    .rf_re_b_o     ( rf_re_b             ),
    .id_ex_pipe_o  ( id_ex_pipe          )
  );

  register_file register_file_inst (
    .clk_i     ( clk_i               ),
    .rst_i     ( rst_i               ),
    .raddr_a_i ( rf_raddr_a          ),
    .raddr_b_i ( rf_raddr_b          ),
    .rdata_a_o ( rf_rdata_a          ),
    .rdata_b_o ( rf_rdata_b          ),
    .we_i      ( rf_we_wb            ),
    .waddr_i   ( ex_wb_pipe.rf_waddr ),
    .wdata_i   ( ex_wb_pipe.rf_wdata )
  );

  controller controller_inst (
    .rf_raddr_a_i ( rf_raddr_a ),
    .rf_raddr_b_i ( rf_raddr_b ),
    .rf_re_a_i    ( rf_re_a    ),
    .rf_re_b_i    ( rf_re_b    ),
    .id_ex_pipe_i ( id_ex_pipe ),
    .ex_wb_pipe_i ( ex_wb_pipe ),
    .ctrl_byp_o   ( ctrl_byp   )
  );

  //////////////////////////////////////////////////////////////////////
  // Execute and write-back
  //////////////////////////////////////////////////////////////////////

  ex_stage ex_stage_inst (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .id_ex_pipe_i ( id_ex_pipe ),
    .ex_result_o  ( ex_result  ),
    .ex_wb_pipe_o ( ex_wb_pipe )
  );

  // Bubbles never write
  assign rf_we_wb = ex_wb_pipe.valid & ex_wb_pipe.rf_we;

  assign wb_valid_o = rf_we_wb;
  assign wb_waddr_o = ex_wb_pipe.rf_waddr;
  assign wb_wdata_o = ex_wb_pipe.rf_wdata;

endmodule

/* tb_core.sv */
/*
 * Testbench for the three-stage core: directed ALU, forwarding and
 * bubble cases, then a seeded random stream against a reference model
 */
`include "core_params.svh"

module tb_core import core_pkg::*; ();

  logic     clk_i = 1'b0;
  logic     rst_i;
  logic     instr_valid_i;
  word_t    instr_i;
  logic     wb_valid_o;
  rf_addr_t wb_waddr_o;
  word_t    wb_wdata_o;

  // Expected write-back, stamped with its cycle
  typedef struct {
    string    name;
    rf_addr_t addr;
    word_t    data;
    int       cyc;
  } exp_entry_t;

  exp_entry_t exp_q[$];
  word_t      shadow_regs [0:`CORE_NUM_REGS-1];
  word_t      lcg_state = 32'hed63;
  string      phase = "reset";
  int         cyc = 0;

  core core_inst (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .wb_valid_o    ( wb_valid_o    ),
    .wb_waddr_o    ( wb_waddr_o    ),
    .wb_wdata_o    ( wb_wdata_o    )
  );

  always #4 clk_i = ~clk_i;

  // Edge counter, read at negedge and after the drive delay
  always @(posedge clk_i) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Two LCG steps, upper halves only
  function automatic word_t rand_word();
    word_t hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], lcg_state[31:16]};
  endfunction

  task automatic fail_run(string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_value(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // Instruction encoders
  function automatic word_t r_type(logic [6:0] f7, rf_addr_t rs2, rf_addr_t rs1,
                                   logic [2:0] f3, rf_addr_t rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, rf_addr_t rs1, logic [2:0] f3,
                                   rf_addr_t rd);
    return {imm, rs1, f3, rd, `CORE_OPC_OP_IMM};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, rf_addr_t rd);
    return {imm, rd, `CORE_OPC_LUI};
  endfunction

  // Reference model, result against the shadow registers in issue order
  function automatic word_t ref_result(word_t instr, output logic writes);
    word_t a;
    word_t b;
    word_t imm_i;
    logic  legal;
    word_t res;
    a     = shadow_regs[instr[19:15]];
    b     = shadow_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    legal = 1'b1;
    res   = '0;
    case (instr[6:0])
      7'b0110011: begin
        if (instr[31:25] == 7'b0000000) begin
          case (instr[14:12])
            3'b000:  res = a + b;
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b110:  res = a | b;
            3'b111:  res = a & b;
            default: legal = 1'b0;
          endcase
        end else if (instr[31:25] == 7'b0100000 && instr[14:12] == 3'b000) begin
          res = a - b;
        end else begin
          legal = 1'b0;
        end
      end
      7'b0010011: begin
        case (instr[14:12])
          3'b000:  res = a + imm_i;
          3'b100:  res = a ^ imm_i;
          3'b110:  res = a | imm_i;
          3'b111:  res = a & imm_i;
          default: legal = 1'b0;
        endcase
      end
      7'b0110111: res = {instr[31:12], 12'b0};
      default:    legal = 1'b0;
    endcase
    writes = legal && (instr[11:7] != 5'd0);
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Drive one instruction, shows up on wb two edges after the drive
  task automatic issue(word_t instr);
    exp_entry_t e;
    logic       writes;
    word_t      val;
    @(posedge clk_i);
    #1;
    instr_valid_i = 1'b1;
    instr_i       = instr;
    val = ref_result(instr, writes);
    if (writes) begin
      shadow_regs[instr[11:7]] = val;
      e.name = phase;
      e.addr = instr[11:7];
      e.data = val;
      e.cyc  = cyc + 2;
      exp_q.push_back(e);
    end
  endtask

  // Idle cycles with junk on the bus
  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      instr_valid_i = 1'b0;
      instr_i       = rand_word();
    end
  endtask

  // LUI then ADDI, low half sign corrected
  task automatic load_reg(rf_addr_t rd, word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    issue(u_type(upper[19:0], rd));
    issue(i_type(value[11:0], rd, `CORE_F3_ADD, rd));
  endtask

  task automatic random_step();
    word_t      r;
    logic [2:0] f3;
    logic [2:0] r_f3 [5];
    logic [2:0] i_f3 [4];
    r_f3 = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    i_f3 = '{3'b000, 3'b100, 3'b110, 3'b111};
    r = rand_word();
    // Registers x0..x7 only, lots of hazards
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
        if (r[12] & r[13]) begin
          issue(r_type(`CORE_F7_SUB, r[8:6], r[5:3], `CORE_F3_ADD, r[2:0]));
        end else begin
          f3 = r_f3[r[11:9] % 5];
          issue(r_type(`CORE_F7_BASE, r[8:6], r[5:3], f3, r[2:0]));
        end
      end
      4'd6, 4'd7, 4'd8, 4'd9: begin
        issue(i_type(r[27:16], r[5:3], i_f3[r[10:9]], r[2:0]));
      end
      4'd10:        issue(u_type(r[27:8], r[2:0]));
      4'd11, 4'd12: issue(rand_word());
      // Any funct3, shifts and SLTI illegal here
      4'd13:        issue(i_type(r[27:16], r[5:3], r[11:9], r[2:0]));
      default:      idle(1 + r[9:8]);
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare_proc
    exp_entry_t e;
    if (rst_i) begin
      compare_value("reset_quiet", 32'd0, {31'd0, wb_valid_o});
    end else if (wb_valid_o !== 1'b0) begin
      if (wb_valid_o !== 1'b1) begin
        fail_run("wb_valid_o is unknown after reset");
      end
      if (exp_q.size() == 0) begin
        fail_run($sformatf("Unexpected register write to x%0d at cycle %0d",
                           wb_waddr_o, cyc));
      end
      e = exp_q.pop_front();
      compare_value({e.name, " addr"}, e.addr, wb_waddr_o);
      compare_value({e.name, " data"}, e.data, wb_wdata_o);
      compare_value({e.name, " cycle"}, e.cyc, cyc);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      shadow_regs[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    #1 rst_i = 1'b0;
    phase = "idle_after_reset";
    idle(4);

    // Every kept operation, negative operands for SUB and SLT
    phase = "alu_ops";
    load_reg(5'd1, 32'hffff_fffb);
    load_reg(5'd2, 32'd7);
    load_reg(5'd3, 32'h8000_0000);
    idle(3);
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_ADD, 5'd4));
    issue(r_type(`CORE_F7_SUB,  5'd2, 5'd1, `CORE_F3_ADD, 5'd5));
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_AND, 5'd6));
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_OR,  5'd7));
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_XOR, 5'd8));
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_SLT, 5'd9));
    issue(r_type(`CORE_F7_BASE, 5'd1, 5'd2, `CORE_F3_SLT, 5'd10));
    issue(r_type(`CORE_F7_BASE, 5'd1, 5'd3, `CORE_F3_SLT, 5'd11));
    issue(r_type(`CORE_F7_SUB,  5'd1, 5'd3, `CORE_F3_ADD, 5'd17));
    issue(i_type(12'hf9c, 5'd1, `CORE_F3_ADD, 5'd12));
    issue(i_type(12'h0f0, 5'd1, `CORE_F3_AND, 5'd13));
    issue(i_type(12'h800, 5'd2, `CORE_F3_OR,  5'd14));
    issue(i_type(12'hfff, 5'd1, `CORE_F3_XOR, 5'd15));
    issue(u_type(20'habcde, 5'd16));
    idle(3);

    // Distances one, two and three
    phase = "forwarding";
    issue(i_type(12'd10, 5'd0, `CORE_F3_ADD, 5'd20));
    issue(r_type(`CORE_F7_BASE, 5'd20, 5'd20, `CORE_F3_ADD, 5'd21));
    issue(r_type(`CORE_F7_BASE, 5'd20, 5'd21, `CORE_F3_XOR, 5'd22));
    issue(r_type(`CORE_F7_SUB,  5'd22, 5'd20, `CORE_F3_ADD, 5'd23));
    issue(r_type(`CORE_F7_BASE, 5'd22, 5'd23, `CORE_F3_SLT, 5'd24));
    issue(r_type(`CORE_F7_BASE, 5'd20, 5'd21, `CORE_F3_OR,  5'd25));
    // Same target in EX and WB, EX must win
    issue(i_type(12'd1, 5'd0,  `CORE_F3_ADD, 5'd26));
    issue(i_type(12'd1, 5'd26, `CORE_F3_ADD, 5'd26));
    issue(i_type(12'd1, 5'd26, `CORE_F3_ADD, 5'd26));
    issue(i_type(12'd0, 5'd26, `CORE_F3_ADD, 5'd27));
    idle(3);

    // x0 targets and illegal encodings stay silent
    phase = "bubbles";
    issue(i_type(12'd55, 5'd0, `CORE_F3_ADD, 5'd0));
    issue(r_type(`CORE_F7_BASE, 5'd0, 5'd0, `CORE_F3_ADD, 5'd28));
    issue(r_type(`CORE_F7_BASE, 5'd2, 5'd1, `CORE_F3_ADD, 5'd0));
    issue(32'hffff_ffff);
    issue(r_type(`CORE_F7_SUB, 5'd2, 5'd1, `CORE_F3_AND, 5'd29));
    issue(i_type(12'd3, 5'd1, 3'b001, 5'd30));
    issue(i_type(12'd0, 5'd0, `CORE_F3_ADD, 5'd29));
    idle(3);

    phase = "random_stream";
    for (int n = 0; n < 300; n++) begin
      random_step();
    end
    idle(1);

    // Drain, then a few quiet cycles for stray writes
    for (int t = 0; t < 20 && exp_q.size() != 0; t++) begin
      @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d expected register writes never appeared", exp_q.size());
      $display("sim failed");
      $fatal(1);
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* all.f */
+incdir+.
core_pkg.sv
register_file.sv
id_stage.sv
ex_stage.sv
controller.sv
core.sv
tb_core.sv
